// ==== common/psram_settings.svh ====
`ifndef PSRAM_SETTINGS_SVH
`define PSRAM_SETTINGS_SVH

// Memory geometry
`define PSRAM_ADDR_WIDTH 16
`define PSRAM_DATA_WIDTH 16

// Host address window, upper bits compared against the base
`define PSRAM_WINDOW_BASE 16'hC000
`define PSRAM_WINDOW_BITS 14

// Default variable latency of the cellular RAM
`define PSRAM_RW_LATENCY 4

// Burst limit and buffering
`define PSRAM_MAX_BURST 16
`define PSRAM_QUEUE_DEPTH 16

`endif

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

`include "psram_settings.svh"

    // Length fields hold burst length minus one
    localparam int LEN_WIDTH = $clog2(`PSRAM_MAX_BURST);

    // Host request, one strobe per burst
    typedef struct packed {
        logic [`PSRAM_ADDR_WIDTH-1:0] addr;
        logic                         write;
        logic [LEN_WIDTH-1:0]         len_m1;
    } bus_req_t;

    typedef struct packed {
        logic [`PSRAM_DATA_WIDTH-1:0] data;
    } wr_beat_t;

    typedef struct packed {
        logic [`PSRAM_DATA_WIDTH-1:0] data;
        logic                         last;
    } rd_beat_t;

    // Admitted command, addr is a word offset inside the window
    typedef struct packed {
        logic [`PSRAM_ADDR_WIDTH-1:0] addr;
        logic                         write;
        logic [LEN_WIDTH-1:0]         len_m1;
    } psram_cmd_t;

endpackage

`default_nettype wire

// ==== common/psram_pkg.sv ====
`default_nettype none

package psram_pkg;

`include "psram_settings.svh"

    // Control pins toward the cellular RAM, mostly active low
    typedef struct packed {
        logic                         ce_n;
        logic                         adv_n;
        logic                         oe_n;
        logic                         we_n;
        logic                         cre;
        logic                         ub_n;
        logic                         lb_n;
        logic                         clk_en;
        logic [`PSRAM_ADDR_WIDTH-1:0] addr;
    } psram_pins_t;

    // Deselected memory, no clock
    localparam psram_pins_t PINS_IDLE = '{
        ce_n: 1'b1,
        adv_n: 1'b1,
        oe_n: 1'b1,
        we_n: 1'b1,
        cre: 1'b0,
        ub_n: 1'b1,
        lb_n: 1'b1,
        clk_en: 1'b0,
        addr: '0
    };

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_WAIT,
        READ_DATA,
        WRITE_ADDR,
        WRITE_WAIT,
        WRITE_DATA
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/burst_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_fifo #(
    parameter type item_t = logic,
    parameter int DEPTH = 16
) (
    input  wire                      clk50MHz,
    input  wire                      reset,
    input  wire                      push,
    input  wire item_t               push_item,
    input  wire                      pop,
    output item_t                    pop_item,
    output logic [$clog2(DEPTH):0]   level,
    output logic                     empty
);

    localparam int PW = $clog2(DEPTH);

    item_t mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    // Drop pushes when full, ignore pops when empty
    assign do_push = push && (level != (PW+1)'(DEPTH));
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk50MHz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + {{PW{1'b0}}, do_push} - {{PW{1'b0}}, do_pop};
        end
    end

    // Head of queue is visible before the pop
    assign pop_item = mem[rd_ptr];
    assign empty    = (level == '0);

endmodule

`default_nettype wire

// ==== source/bus_request_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module bus_request_decoder (
    input  wire                                    clk50MHz,
    input  wire                                    reset,
    input  wire                                    req_valid,
    input  wire bus_pkg::bus_req_t                 req,
    input  wire [$clog2(`PSRAM_QUEUE_DEPTH):0]     wq_level,
    input  wire                                    busy,
    output logic                                   req_accept,
    output logic                                   req_reject,
    output logic                                   cmd_valid,
    output bus_pkg::psram_cmd_t                    cmd
);

    localparam int AW = `PSRAM_ADDR_WIDTH;
    localparam int WB = `PSRAM_WINDOW_BITS;
    localparam int LW = $clog2(`PSRAM_QUEUE_DEPTH) + 1;
    localparam logic [AW-1:0] WINDOW_BASE = `PSRAM_WINDOW_BASE;

    logic          in_window;
    logic          blocked;
    logic          short_queue;
    logic          admit;
    logic [LW-1:0] beats_needed;

    assign in_window = (req.addr[AW-1:WB] == WINDOW_BASE[AW-1:WB]);

    // A command issued last cycle has not yet raised busy
    assign blocked = busy || cmd_valid;

    // All write data must already sit in the queue
    assign beats_needed = LW'(req.len_m1) + LW'(1);
    assign short_queue  = req.write && (wq_level < beats_needed);

    assign admit = in_window && !blocked && !short_queue;

    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            req_accept <= 1'b0;
            req_reject <= 1'b0;
        end else begin
            req_accept <= req_valid && admit;
            req_reject <= req_valid && !admit;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (req_valid) begin
            cmd.addr   <= {{(AW-WB){1'b0}}, req.addr[WB-1:0]};
            cmd.write  <= req.write;
            cmd.len_m1 <= req.len_m1;
        end
    end

    // Accepted command goes to the sequencer in the same cycle as the ack
    assign cmd_valid = req_accept;

endmodule

`default_nettype wire

// ==== psram_ctrl/psram_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module psram_sequencer (
    input  wire                               clk50MHz,
    input  wire                               reset,
    input  wire                               cmd_valid,
    input  wire bus_pkg::psram_cmd_t          cmd,
    input  wire [`PSRAM_DATA_WIDTH-1:0]       mdata_in,
    input  wire                               mwait,
    input  wire bus_pkg::wr_beat_t            wq_data,
    output logic                              wq_pop,
    output psram_pkg::psram_pins_t            pins,
    output logic [`PSRAM_DATA_WIDTH-1:0]      mdata_out,
    output logic                              mdata_oe,
    output logic                              busy,
    output logic                              rd_capture,
    output logic [`PSRAM_DATA_WIDTH-1:0]      rd_data,
    output logic                              rd_done
);

    localparam int LAT = `PSRAM_RW_LATENCY;
    localparam int LCW = (LAT > 1) ? $clog2(LAT) : 1;

    psram_pkg::seq_state_t state;
    psram_pkg::seq_state_t state_next;

    logic [LCW-1:0]                   lat_cnt;
    logic [bus_pkg::LEN_WIDTH-1:0]    beat_cnt;
    logic [`PSRAM_ADDR_WIDTH-1:0]     addr;

    logic in_wait;
    logic in_data;
    logic lat_done;
    logic beat_ok;
    logic last_beat;

    assign in_wait   = (state == psram_pkg::READ_WAIT) || (state == psram_pkg::WRITE_WAIT);
    assign in_data   = (state == psram_pkg::READ_DATA) || (state == psram_pkg::WRITE_DATA);
    assign lat_done  = (lat_cnt == LCW'(LAT - 1));
    // mwait stretches the current beat by one cycle
    assign beat_ok   = in_data && !mwait;
    assign last_beat = (beat_cnt == '0);

    always_comb begin
        state_next = state;
        case (state)
            psram_pkg::IDLE: begin
                if (cmd_valid) begin
                    state_next = cmd.write ? psram_pkg::WRITE_ADDR : psram_pkg::READ_ADDR;
                end
            end
            psram_pkg::READ_ADDR:  state_next = psram_pkg::READ_WAIT;
            psram_pkg::WRITE_ADDR: state_next = psram_pkg::WRITE_WAIT;
            psram_pkg::READ_WAIT: begin
                if (lat_done) begin
                    state_next = psram_pkg::READ_DATA;
                end
            end
            psram_pkg::WRITE_WAIT: begin
                if (lat_done) begin
                    state_next = psram_pkg::WRITE_DATA;
                end
            end
            psram_pkg::READ_DATA,
            psram_pkg::WRITE_DATA: begin
                if (beat_ok && last_beat) begin
                    state_next = psram_pkg::IDLE;
                end
            end
            default: state_next = psram_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            state    <= psram_pkg::IDLE;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (in_wait) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
            if (state == psram_pkg::IDLE && cmd_valid) begin
                beat_cnt <= cmd.len_m1;
            end else if (beat_ok) begin
                beat_cnt <= beat_cnt - 1'b1;
            end
        end
    end

    // Word address, advanced after every completed beat
    always_ff @(posedge clk50MHz) begin
        if (state == psram_pkg::IDLE && cmd_valid) begin
            addr <= cmd.addr;
        end else if (beat_ok) begin
            addr <= addr + 1'b1;
        end
    end

    // Pin decode
    always_comb begin
        pins      = psram_pkg::PINS_IDLE;
        pins.addr = addr;
        if (state != psram_pkg::IDLE) begin
            pins.ce_n   = 1'b0;
            pins.clk_en = 1'b1;
        end
        case (state)
            psram_pkg::READ_ADDR:  pins.adv_n = 1'b0;
            psram_pkg::WRITE_ADDR: begin
                pins.adv_n = 1'b0;
                pins.we_n  = 1'b0;
            end
            psram_pkg::READ_DATA:  pins.oe_n = 1'b0;
            default: ;
        endcase
    end

    // Write beats come straight from the queue head
    assign mdata_out = wq_data.data;
    assign mdata_oe  = (state == psram_pkg::WRITE_DATA);
    assign wq_pop    = beat_ok && (state == psram_pkg::WRITE_DATA);

    assign rd_capture = beat_ok && (state == psram_pkg::READ_DATA);
    assign rd_data    = mdata_in;
    assign rd_done    = rd_capture && last_beat;

    assign busy = (state != psram_pkg::IDLE);

endmodule

`default_nettype wire

// ==== source/read_result_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module read_result_collector (
    input  wire                           clk50MHz,
    input  wire                           reset,
    input  wire                           rd_capture,
    input  wire [`PSRAM_DATA_WIDTH-1:0]   rd_data,
    input  wire                           rd_done,
    output logic                          rsp_valid,
    output bus_pkg::rd_beat_t             rsp
);

    bus_pkg::rd_beat_t cap_item;
    logic              draining;
    logic              buf_empty;
    logic              buf_pop;

    // Final captured word carries the last tag
    assign cap_item.data = rd_data;
    assign cap_item.last = rd_done;

    burst_fifo #(
        .item_t (bus_pkg::rd_beat_t),
        .DEPTH  (`PSRAM_QUEUE_DEPTH)
    ) rd_buf (
        .clk50MHz  (clk50MHz),
        .reset     (reset),
        .push      (rd_capture),
        .push_item (cap_item),
        .pop       (buf_pop),
        .pop_item  (rsp),
        .level     (),
        .empty     (buf_empty)
    );

    assign buf_pop   = draining && !buf_empty;
    assign rsp_valid = buf_pop;

    // Release starts only once the whole burst is buffered
    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            draining <= 1'b0;
        end else if (rd_done) begin
            draining <= 1'b1;
        end else if (buf_pop && rsp.last) begin
            draining <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/psram_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module psram_subsystem (
    input  wire                           clk50MHz,
    input  wire                           reset,
    input  wire                           req_valid,
    input  wire bus_pkg::bus_req_t        req,
    input  wire                           wdata_valid,
    input  wire bus_pkg::wr_beat_t        wdata,
    output logic                          req_accept,
    output logic                          req_reject,
    output logic                          busy,
    output logic                          rsp_valid,
    output bus_pkg::rd_beat_t             rsp,
    output psram_pkg::psram_pins_t        pins,
    output logic [`PSRAM_DATA_WIDTH-1:0]  mdata_out,
    output logic                          mdata_oe,
    input  wire [`PSRAM_DATA_WIDTH-1:0]   mdata_in,
    input  wire                           mwait
);

    logic [$clog2(`PSRAM_QUEUE_DEPTH):0] wq_level;
    bus_pkg::wr_beat_t                   wq_data;
    logic                                wq_pop;
    logic                                cmd_valid;
    bus_pkg::psram_cmd_t                 cmd;
    logic                                rd_capture;
    logic [`PSRAM_DATA_WIDTH-1:0]        rd_data;
    logic                                rd_done;

    bus_request_decoder decoder (
        .clk50MHz   (clk50MHz),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .wq_level   (wq_level),
        .busy       (busy),
        .req_accept (req_accept),
        .req_reject (req_reject),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

    // Host write words wait here until their command runs
    burst_fifo #(
        .item_t (bus_pkg::wr_beat_t),
        .DEPTH  (`PSRAM_QUEUE_DEPTH)
    ) write_queue (
        .clk50MHz  (clk50MHz),
        .reset     (reset),
        .push      (wdata_valid),
        .push_item (wdata),
        .pop       (wq_pop),
        .pop_item  (wq_data),
        .level     (wq_level),
        .empty     ()
    );

    psram_sequencer sequencer (
        .clk50MHz   (clk50MHz),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .mdata_in   (mdata_in),
        .mwait      (mwait),
        .wq_data    (wq_data),
        .wq_pop     (wq_pop),
        .pins       (pins),
        .mdata_out  (mdata_out),
        .mdata_oe   (mdata_oe),
        .busy       (busy),
        .rd_capture (rd_capture),
        .rd_data    (rd_data),
        .rd_done    (rd_done)
    );

    read_result_collector collector (
        .clk50MHz   (clk50MHz),
        .reset      (reset),
        .rd_capture (rd_capture),
        .rd_data    (rd_data),
        .rd_done    (rd_done),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// ==== tests/psram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module psram_model (
    input  wire                           clk50MHz,
    input  wire psram_pkg::psram_pins_t   pins,
    input  wire [`PSRAM_DATA_WIDTH-1:0]   mdata_out,
    input  wire                           mdata_oe,
    output logic [`PSRAM_DATA_WIDTH-1:0]  mdata_in,
    output logic                          mwait
);

    localparam int AW = `PSRAM_ADDR_WIDTH;
    localparam int DW = `PSRAM_DATA_WIDTH;
    localparam int LAT = `PSRAM_RW_LATENCY;

    logic [DW-1:0] mem [1 << AW];
    logic [AW-1:0] burst_addr;
    logic          is_write;
    logic          data_phase;
    int            lat_cnt;
    integer        seed = 32'h4959;

    // Power-up contents, every word tied to its full address
    initial begin
        logic [AW-1:0] a;
        for (int i = 0; i < (1 << AW); i++) begin
            a = AW'(i);
            mem[i] = {a[7:0], a[15:8]} ^ 16'h3C5A;
        end
    end

    // Address latch, fixed latency count, then one word per unstalled cycle
    // A deselected or unclocked memory drops the burst
    always @(posedge clk50MHz) begin
        if (pins.ce_n || !pins.clk_en) begin
            data_phase <= 1'b0;
            lat_cnt    <= 0;
        end else if (!pins.adv_n) begin
            burst_addr <= pins.addr;
            is_write   <= !pins.we_n;
            data_phase <= 1'b0;
            lat_cnt    <= 0;
        end else if (!data_phase) begin
            if (lat_cnt == LAT - 1) begin
                data_phase <= 1'b1;
            end
            lat_cnt <= lat_cnt + 1;
        end else if (!mwait) begin
            if (is_write && mdata_oe) begin
                mem[burst_addr] <= mdata_out;
            end
            burst_addr <= burst_addr + 1'b1;
        end
    end

    assign mdata_in = (data_phase && !is_write && !pins.oe_n) ? mem[burst_addr] : '0;

    // Roughly one data cycle in four is stalled
    initial begin
        mwait = 1'b0;
        forever begin
            @(posedge clk50MHz);
            #2;
            mwait = data_phase && (($random(seed) & 3) == 0);
        end
    end

endmodule

`default_nettype wire

// ==== tests/psram_props.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module psram_props (
    input  wire                           clk50MHz,
    input  wire                           reset,
    input  wire psram_pkg::psram_pins_t   pins,
    input  wire psram_pkg::seq_state_t    state
);

    localparam int LAT = `PSRAM_RW_LATENCY;

    int unsigned fail_count = 0;
    int          wait_run;
    logic        in_wait;
    logic        in_data;

    assign in_wait = (state == psram_pkg::READ_WAIT) || (state == psram_pkg::WRITE_WAIT);
    assign in_data = (state == psram_pkg::READ_DATA) || (state == psram_pkg::WRITE_DATA);

    // Length of the current run of wait cycles
    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            wait_run <= 0;
        end else if (in_wait) begin
            wait_run <= wait_run + 1;
        end else begin
            wait_run <= 0;
        end
    end

    adv_single: assert property (@(posedge clk50MHz) disable iff (reset)
        !pins.adv_n |=> pins.adv_n)
        else begin
            $error("adv_n stayed low for more than one cycle");
            fail_count++;
        end

    no_bus_fight: assert property (@(posedge clk50MHz) disable iff (reset)
        pins.oe_n || pins.we_n)
        else begin
            $error("oe_n and we_n both low");
            fail_count++;
        end

    wait_length: assert property (@(posedge clk50MHz) disable iff (reset)
        (in_data && !$past(in_data)) |-> (wait_run == LAT))
        else begin
            $error("wait phase length differs from the configured latency");
            fail_count++;
        end

endmodule

bind psram_sequencer psram_props props (
    .clk50MHz (clk50MHz),
    .reset    (reset),
    .pins     (pins),
    .state    (state)
);

`default_nettype wire

// ==== tests/psram_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "psram_settings.svh"

module psram_tb;

    localparam int AW = `PSRAM_ADDR_WIDTH;
    localparam int DW = `PSRAM_DATA_WIDTH;
    localparam int WB = `PSRAM_WINDOW_BITS;
    localparam int LAT = `PSRAM_RW_LATENCY;
    localparam int LW = bus_pkg::LEN_WIDTH;
    localparam int TIMEOUT = 400;
    localparam int ENTRIES = 17;

    // Short write pushes one word too few, busy write probes during a read
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_SHORT_WRITE,
        OP_BUSY_WRITE
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic [4:0]  len;
        logic        accept;
    } entry_t;

    entry_t stimulus [ENTRIES] = '{
        '{OP_WRITE,       16'hC010, 5'd1,  1'b1},
        '{OP_READ,        16'hC010, 5'd1,  1'b1},
        '{OP_WRITE,       16'hC100, 5'd4,  1'b1},
        '{OP_READ,        16'hC100, 5'd4,  1'b1},
        '{OP_WRITE,       16'hFF00, 5'd16, 1'b1},
        '{OP_READ,        16'hFF00, 5'd16, 1'b1},
        '{OP_READ,        16'hC203, 5'd1,  1'b1},
        '{OP_READ,        16'h4000, 5'd2,  1'b0},
        '{OP_READ,        16'hBFFF, 5'd1,  1'b0},
        '{OP_SHORT_WRITE, 16'hC300, 5'd4,  1'b0},
        '{OP_READ,        16'hC300, 5'd4,  1'b1},
        '{OP_BUSY_WRITE,  16'hC100, 5'd16, 1'b0},
        '{OP_READ,        16'hC100, 5'd4,  1'b1},
        '{OP_WRITE,       16'hC020, 5'd2,  1'b1},
        '{OP_READ,        16'hC020, 5'd2,  1'b1},
        '{OP_WRITE,       16'hC030, 5'd4,  1'b1},
        '{OP_READ,        16'hC030, 5'd4,  1'b1}
    };

    logic                   clk50MHz;
    logic                   reset;
    logic                   req_valid;
    bus_pkg::bus_req_t      req;
    logic                   wdata_valid;
    bus_pkg::wr_beat_t      wdata;
    logic                   req_accept;
    logic                   req_reject;
    logic                   busy;
    logic                   rsp_valid;
    bus_pkg::rd_beat_t      rsp;
    psram_pkg::psram_pins_t pins;
    logic [DW-1:0]          mdata_out;
    logic                   mdata_oe;
    logic [DW-1:0]          mdata_in;
    logic                   mwait;

    logic [DW-1:0] shadow [1 << AW];
    logic [DW-1:0] pending [$];
    integer        seed = 32'h4959;

    psram_subsystem uut (
        .clk50MHz    (clk50MHz),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .wdata_valid (wdata_valid),
        .wdata       (wdata),
        .req_accept  (req_accept),
        .req_reject  (req_reject),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .pins        (pins),
        .mdata_out   (mdata_out),
        .mdata_oe    (mdata_oe),
        .mdata_in    (mdata_in),
        .mwait       (mwait)
    );

    psram_model mem_model (
        .clk50MHz  (clk50MHz),
        .pins      (pins),
        .mdata_out (mdata_out),
        .mdata_oe  (mdata_oe),
        .mdata_in  (mdata_in),
        .mwait     (mwait)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    task automatic step();
        @(posedge clk50MHz);
        #2;
    endtask

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic wait_busy_level(input logic level);
        for (int n = 0; n < TIMEOUT && busy !== level; n++) begin
            step();
        end
        assert (busy === level) else begin
            $display("Timed out waiting for busy to become %0b", level);
            fail_run();
        end
    endtask

    task automatic check_idle();
        check_value("pins.ce_n", pins.ce_n, 1);
        check_value("pins.adv_n", pins.adv_n, 1);
        check_value("pins.oe_n", pins.oe_n, 1);
        check_value("pins.we_n", pins.we_n, 1);
        check_value("pins.cre", pins.cre, 0);
        check_value("pins.ub_n", pins.ub_n, 1);
        check_value("pins.lb_n", pins.lb_n, 1);
        check_value("pins.clk_en", pins.clk_en, 0);
        check_value("busy", busy, 0);
        check_value("rsp_valid", rsp_valid, 0);
        check_value("req_accept", req_accept, 0);
        check_value("req_reject", req_reject, 0);
        check_value("mdata_oe", mdata_oe, 0);
        check_value("wq_pop", uut.wq_pop, 0);
    endtask

    // Random write words, remembered in host order
    task automatic push_words(input int count);
        logic [DW-1:0] word;
        for (int i = 0; i < count; i++) begin
            word = DW'($random(seed));
            wdata_valid = 1'b1;
            wdata.data = word;
            pending.push_back(word);
            step();
        end
        wdata_valid = 1'b0;
    endtask

    // Ack must be a single pulse exactly one cycle after the strobe
    task automatic send_request(input logic write, input logic [15:0] addr,
                                input logic [4:0] len, input logic accept);
        check_value("req_accept", req_accept, 0);
        check_value("req_reject", req_reject, 0);
        req_valid = 1'b1;
        req.addr = addr;
        req.write = write;
        req.len_m1 = LW'(len - 5'd1);
        step();
        req_valid = 1'b0;
        check_value("req_accept", req_accept, accept);
        check_value("req_reject", req_reject, !accept);
        step();
        check_value("req_accept", req_accept, 0);
        check_value("req_reject", req_reject, 0);
    endtask

    task automatic collect_read(input int offset, input int len);
        for (int n = 0; n < TIMEOUT && !rsp_valid; n++) begin
            step();
        end
        assert (rsp_valid) else begin
            $display("Timed out waiting for read data at offset 0x%0h", offset);
            fail_run();
        end
        // Beats must arrive back to back
        for (int i = 0; i < len; i++) begin
            check_value("rsp_valid", rsp_valid, 1);
            check_value("rsp.data", rsp.data, shadow[offset + i]);
            check_value("rsp.last", rsp.last, i == len - 1);
            step();
        end
        check_value("rsp_valid", rsp_valid, 0);
    endtask

    task automatic watch_no_select(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_value("pins.ce_n", pins.ce_n, 1);
            step();
        end
    endtask

    task automatic run_entry(input entry_t ent);
        int offset;
        offset = int'(ent.addr[WB-1:0]);
        case (ent.op)
            OP_WRITE: begin
                push_words(int'(ent.len));
                send_request(1'b1, ent.addr, ent.len, ent.accept);
                if (ent.accept) begin
                    wait_busy_level(1'b1);
                    wait_busy_level(1'b0);
                    for (int i = 0; i < int'(ent.len); i++) begin
                        shadow[offset + i] = pending.pop_front();
                    end
                end else begin
                    watch_no_select(LAT + 4);
                end
            end
            OP_READ: begin
                send_request(1'b0, ent.addr, ent.len, ent.accept);
                if (ent.accept) begin
                    collect_read(offset, int'(ent.len));
                end else begin
                    watch_no_select(LAT + 4);
                end
            end
            OP_SHORT_WRITE: begin
                push_words(int'(ent.len) - 1);
                send_request(1'b1, ent.addr, ent.len, ent.accept);
                watch_no_select(LAT + 4);
            end
            default: begin
                send_request(1'b0, ent.addr, ent.len, 1'b1);
                wait_busy_level(1'b1);
                push_words(1);
                check_value("busy", busy, 1);
                send_request(1'b1, ent.addr, 5'd1, ent.accept);
                collect_read(offset, int'(ent.len));
            end
        endcase
    endtask

    initial begin
        logic [AW-1:0] a;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        wdata_valid = 1'b0;
        wdata = '0;
        // Same power-up contents as the memory model
        for (int i = 0; i < (1 << AW); i++) begin
            a = AW'(i);
            shadow[i] = {a[7:0], a[15:8]} ^ 16'h3C5A;
        end
        repeat (8) @(posedge clk50MHz);
        #2;
        reset = 1'b0;
        step();
        check_idle();
        for (int e = 0; e < ENTRIES; e++) begin
            run_entry(stimulus[e]);
            wait_busy_level(1'b0);
            check_idle();
        end
        if (uut.sequencer.props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Pin protocol assertions failed during the run");
            fail_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/bus_pkg.sv
common/psram_pkg.sv
source/burst_fifo.sv
source/bus_request_decoder.sv
psram_ctrl/psram_sequencer.sv
source/read_result_collector.sv
source/psram_subsystem.sv
tests/psram_model.sv
tests/psram_props.sv
tests/psram_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := psram_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
